/* logic/gamePkg.sv */
// Colour memory game definitions
`default_nettype none

package gamePkg;

	// round and timing constants
	localparam int sequenceLength = 5;
	localparam int maxLevel = 5;
	localparam int pauseUnit = 16;

	// pixel counts of the three screen regions
	localparam int fullPixels = 19200;
	localparam int canvasPixels = 8050;
	localparam int answerPixels = 357;

	typedef logic [14:0] pixelCountT;
	typedef logic [2:0] levelT;
	typedef logic [1:0] symbolT;
	typedef symbolT [sequenceLength-1:0] symbolSeqT;
	typedef logic [2:0] slotT;

	typedef enum logic [1:0] {full, canvas, answer} regionT;

	typedef enum logic [3:0] {
		black, startScreen, gameScreen, red, green, blue, yellow, winScreen, loseScreen
	} paletteT;

	// generateSeq stands in for the reserved word generate
	typedef enum logic [4:0] {
		idle, drawStartScreen, getLevel, checkLevel, drawGameScreen, generateSeq,
		readSymbol, pauseSymbol, drawSymbol, drawClear, waitKey, storeKey,
		drawAnswer, verify, drawResult, win, lose
	} gameStateT;

	// the four buttons in the order red, green, blue, yellow
	function automatic paletteT symbolColour(input symbolT symbol);
		case (symbol)
			2'd0: return red;
			2'd1: return green;
			2'd2: return blue;
			default: return yellow;
		endcase
	endfunction

	function automatic pixelCountT regionPixels(input regionT region);
		case (region)
			canvas: return pixelCountT'(canvasPixels);
			answer: return pixelCountT'(answerPixels);
			default: return pixelCountT'(fullPixels);
		endcase
	endfunction

endpackage

`default_nettype wire

/* logic/drawIf.sv */
// Screen drawing interface
`timescale 1ns/1ps
`default_nettype none

interface drawIf;
	import gamePkg::*;

	// drawStart is only raised while drawBusy is low
	logic drawStart;
	regionT drawRegion;
	paletteT drawColour;
	logic drawDone;
	logic drawBusy;

	modport controller (output drawStart, drawRegion, drawColour, input drawDone, drawBusy);
	modport painter (input drawStart, drawRegion, drawColour, output drawDone, drawBusy);

endinterface

`default_nettype wire

/* logic/gameControl.sv */
// Game state machine
`timescale 1ns/1ps
`default_nettype none

module gameControl (
	input wire clock,
	input wire reset,
	input wire start,
	input wire gamePkg::levelT level,
	input wire keyPressed,
	input wire continueKey,
	input wire gamePkg::symbolT showSymbol,
	input wire showDone,
	input wire gamePkg::symbolT lastKey,
	input wire slotsFull,
	input wire allMatch,
	input wire pauseDone,
	drawIf.controller draw,
	output logic captureSequence,
	output logic showNext,
	output logic storeKey,
	output logic pauseEnable
);
	import gamePkg::*;

	gameStateT state;
	gameStateT nextState;

	always_comb begin
		nextState = state;
		case (state)
			idle: begin
				if (start)
					nextState = drawStartScreen;
			end
			drawStartScreen: begin
				if (draw.drawDone)
					nextState = getLevel;
			end
			getLevel: begin
				if (start)
					nextState = checkLevel;
			end
			checkLevel: begin
				// zero and anything above the top level send the player back
				if (level == 3'd0 || level > levelT'(maxLevel))
					nextState = getLevel;
				else
					nextState = drawGameScreen;
			end
			drawGameScreen: begin
				if (draw.drawDone)
					nextState = generateSeq;
			end
			generateSeq: nextState = readSymbol;
			readSymbol: begin
				if (showDone)
					nextState = drawClear;
				else
					nextState = pauseSymbol;
			end
			pauseSymbol: begin
				if (pauseDone)
					nextState = drawSymbol;
			end
			drawSymbol: begin
				if (draw.drawDone)
					nextState = readSymbol;
			end
			drawClear: begin
				if (draw.drawDone)
					nextState = waitKey;
			end
			waitKey: begin
				if (slotsFull)
					nextState = verify;
				else if (keyPressed)
					nextState = gamePkg::storeKey;
			end
			// the port of the same name hides the state inside this module
			gamePkg::storeKey: nextState = drawAnswer;
			drawAnswer: begin
				if (draw.drawDone)
					nextState = waitKey;
			end
			verify: nextState = drawResult;
			drawResult: begin
				if (draw.drawDone)
					nextState = allMatch ? win : lose;
			end
			win, lose: begin
				if (continueKey)
					nextState = drawStartScreen;
			end
			default: nextState = idle;
		endcase
	end

	// a drawing is requested once, in the first cycle of each drawing state
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			draw.drawStart <= 1'b0;
		end else begin
			state <= nextState;
			draw.drawStart <= (nextState != state) && (nextState inside
				{drawStartScreen, drawGameScreen, drawSymbol, drawClear, drawAnswer, drawResult});
		end
	end

	always_comb begin
		case (state)
			drawStartScreen: begin
				draw.drawRegion = canvas;
				draw.drawColour = startScreen;
			end
			drawGameScreen: begin
				draw.drawRegion = full;
				draw.drawColour = gameScreen;
			end
			drawSymbol: begin
				draw.drawRegion = canvas;
				draw.drawColour = symbolColour(showSymbol);
			end
			drawAnswer: begin
				draw.drawRegion = answer;
				draw.drawColour = symbolColour(lastKey);
			end
			drawResult: begin
				draw.drawRegion = canvas;
				draw.drawColour = allMatch ? winScreen : loseScreen;
			end
			default: begin
				draw.drawRegion = canvas;
				draw.drawColour = black;
			end
		endcase
	end

	assign captureSequence = (state == generateSeq);
	assign pauseEnable = (state == pauseSymbol);

	// the pointer moves on as the symbol finishes painting
	assign showNext = (state == drawSymbol) && draw.drawDone;

	// the key is taken together with its strobe so keySymbol need not be held
	assign storeKey = (state == waitKey) && keyPressed && !slotsFull;

	drawStartWhileBusy: assert property (@(posedge clock) disable iff (reset)
		draw.drawStart |-> !draw.drawBusy);

endmodule

`default_nettype wire

/* logic/screenPainter.sv */
// Region pixel painter
`timescale 1ns/1ps
`default_nettype none

module screenPainter (
	input wire clock,
	input wire reset,
	drawIf.painter draw,
	output logic plot,
	output gamePkg::paletteT pixelColour,
	output gamePkg::regionT pixelRegion,
	output gamePkg::pixelCountT pixelIndex
);
	import gamePkg::*;

	logic busy;
	logic lastPixel;
	pixelCountT count;
	pixelCountT lastIndex;
	regionT regionReg;
	paletteT colourReg;

	assign lastIndex = regionPixels(regionReg) - 15'd1;
	assign lastPixel = busy && (count == lastIndex);

	// region and colour stay fixed for the whole run
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
			regionReg <= full;
			colourReg <= black;
		end else if (draw.drawStart) begin
			busy <= 1'b1;
			count <= '0;
			regionReg <= draw.drawRegion;
			colourReg <= draw.drawColour;
		end else if (busy) begin
			if (lastPixel)
				busy <= 1'b0;
			else
				count <= count + 15'd1;
		end
	end

	assign plot = busy;
	assign pixelIndex = count;
	assign pixelColour = colourReg;
	assign pixelRegion = regionReg;
	assign draw.drawBusy = busy;
	assign draw.drawDone = lastPixel;

	plotInsideRegion: assert property (@(posedge clock) disable iff (reset)
		plot |-> pixelIndex < regionPixels(pixelRegion));

endmodule

`default_nettype wire

/* logic/sequenceStore.sv */
// Random sequence store
`timescale 1ns/1ps
`default_nettype none

module sequenceStore (
	input wire clock,
	input wire reset,
	input wire captureSequence,
	input wire showNext,
	output gamePkg::symbolT showSymbol,
	output logic showDone,
	output gamePkg::symbolSeqT storedSeq
);
	import gamePkg::*;

	logic [15:0] lfsr;
	slotT pointer;

	// taps 16, 14, 13 and 11 give a maximal length sequence
	always_ff @(posedge clock) begin
		if (reset)
			lfsr <= 16'hace1;
		else
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	end

	// the player's timing of the start press decides which bits are taken
	always_ff @(posedge clock) begin
		if (captureSequence)
			storedSeq <= lfsr[9:0];
	end

	always_ff @(posedge clock) begin
		if (reset)
			pointer <= '0;
		else if (captureSequence)
			pointer <= '0;
		else if (showNext && !showDone)
			pointer <= pointer + 3'd1;
	end

	assign showDone = (pointer == slotT'(sequenceLength));

	// past the last symbol there is nothing left to show
	always_comb begin
		if (showDone)
			showSymbol = '0;
		else
			showSymbol = storedSeq[pointer];
	end

endmodule

`default_nettype wire

/* logic/pauseTimer.sv */
// Level scaled pause timer
`timescale 1ns/1ps
`default_nettype none

module pauseTimer (
	input wire clock,
	input wire reset,
	input wire gamePkg::levelT level,
	input wire pauseEnable,
	output logic pauseDone
);
	import gamePkg::*;

	levelT levelHeld;
	logic [6:0] count;
	logic [6:0] limit;
	logic fired;

	// the level is frozen for the length of one pause
	always_ff @(posedge clock) begin
		if (!pauseEnable)
			levelHeld <= level;
	end

	assign limit = 7'(levelHeld * pauseUnit);

	always_ff @(posedge clock) begin
		if (reset || !pauseEnable) begin
			count <= '0;
			fired <= 1'b0;
		end else if (!fired) begin
			count <= count + 7'd1;
			if (pauseDone)
				fired <= 1'b1;
		end
	end

	assign pauseDone = pauseEnable && !fired && (count == limit - 7'd1);

	// even the shortest pause lasts one full unit of enabled cycles
	doneAfterFullUnit: assert property (@(posedge clock) disable iff (reset)
		pauseDone |-> $past(pauseEnable, pauseUnit - 1));

endmodule

`default_nettype wire

/* logic/answerCheck.sv */
// Answer store and compare
`timescale 1ns/1ps
`default_nettype none

module answerCheck (
	input wire clock,
	input wire reset,
	input wire storeKey,
	input wire gamePkg::symbolT keySymbol,
	input wire gamePkg::symbolSeqT storedSeq,
	input wire captureSequence,
	output gamePkg::symbolT lastKey,
	output logic slotsFull,
	output logic allMatch
);
	import gamePkg::*;

	slotT slot;
	logic matchFlag;

	always_ff @(posedge clock) begin
		if (reset) begin
			slot <= '0;
			matchFlag <= 1'b0;
		end else if (captureSequence) begin
			slot <= '0;
			matchFlag <= 1'b1;
		end else if (storeKey) begin
			// one wrong key is enough to lose the round
			if (keySymbol != storedSeq[slot])
				matchFlag <= 1'b0;
			slot <= slot + 3'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (storeKey)
			lastKey <= keySymbol;
	end

	assign slotsFull = (slot == slotT'(sequenceLength));
	assign allMatch = matchFlag;

	noKeyWhenFull: assert property (@(posedge clock) disable iff (reset)
		storeKey |-> !slotsFull);

endmodule

`default_nettype wire

/* logic/colourMemoryGame.sv */
// Colour memory game top level
`timescale 1ns/1ps
`default_nettype none

module colourMemoryGame (
	input wire clock,
	input wire reset,
	input wire start,
	input wire gamePkg::levelT level,
	input wire keyPressed,
	input wire gamePkg::symbolT keySymbol,
	input wire continueKey,
	output logic plot,
	output gamePkg::paletteT pixelColour,
	output gamePkg::regionT pixelRegion,
	output gamePkg::pixelCountT pixelIndex
);
	import gamePkg::*;

	logic captureSequence;
	logic showNext;
	logic storeKey;
	logic pauseEnable;
	logic pauseDone;
	logic showDone;
	logic slotsFull;
	logic allMatch;
	symbolT showSymbol;
	symbolT lastKey;
	symbolSeqT storedSeq;

	drawIf draw ();

	gameControl control (
		.clock(clock),
		.reset(reset),
		.start(start),
		.level(level),
		.keyPressed(keyPressed),
		.continueKey(continueKey),
		.showSymbol(showSymbol),
		.showDone(showDone),
		.lastKey(lastKey),
		.slotsFull(slotsFull),
		.allMatch(allMatch),
		.pauseDone(pauseDone),
		.draw(draw.controller),
		.captureSequence(captureSequence),
		.showNext(showNext),
		.storeKey(storeKey),
		.pauseEnable(pauseEnable)
	);

	screenPainter painter (
		.clock(clock),
		.reset(reset),
		.draw(draw.painter),
		.plot(plot),
		.pixelColour(pixelColour),
		.pixelRegion(pixelRegion),
		.pixelIndex(pixelIndex)
	);

	sequenceStore store (
		.clock(clock),
		.reset(reset),
		.captureSequence(captureSequence),
		.showNext(showNext),
		.showSymbol(showSymbol),
		.showDone(showDone),
		.storedSeq(storedSeq)
	);

	pauseTimer timer (
		.clock(clock),
		.reset(reset),
		.level(level),
		.pauseEnable(pauseEnable),
		.pauseDone(pauseDone)
	);

	answerCheck answers (
		.clock(clock),
		.reset(reset),
		.storeKey(storeKey),
		.keySymbol(keySymbol),
		.storedSeq(storedSeq),
		.captureSequence(captureSequence),
		.lastKey(lastKey),
		.slotsFull(slotsFull),
		.allMatch(allMatch)
	);

endmodule

`default_nettype wire

/* verification/clockGen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clock,
	output logic reset
);

	// 40 ns period
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// reset drops just after the eighth rising edge, like the other inputs
	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

/* verification/gameTb.sv */
// Colour memory game testbench
`timescale 1ns/1ps
`default_nettype none

module gameTb;
	import gamePkg::*;

	// two rounds take about 85000 cycles each, so this leaves a wide margin
	localparam int timeoutCycles = 400000;

	logic clock;
	logic reset;
	logic start;
	levelT level;
	logic keyPressed;
	symbolT keySymbol;
	logic continueKey;
	logic plot;
	paletteT pixelColour;
	regionT pixelRegion;
	pixelCountT pixelIndex;

	// phase flags that the assertions depend on
	logic idlePhase;
	logic quietWindow;
	logic answersAllowed;

	// one entry per painted run
	paletteT runColour[$];
	regionT runRegion[$];
	int runLength[$];
	int runStart[$];
	int runEnd[$];
	paletteT curColour;
	regionT curRegion;
	int curLength;
	int curStart;
	logic inRun = 1'b0;
	int cycle = 0;
	int runsTaken;
	int runIdx;
	symbolT shown[sequenceLength];
	int seed;
	int errorCount;
	int passCount;
	int failCount;
	int errorsBefore;
	int wrongSlot;

	clockGen clocks (.clock(clock), .reset(reset));

	colourMemoryGame uut (
		.clock(clock),
		.reset(reset),
		.start(start),
		.level(level),
		.keyPressed(keyPressed),
		.keySymbol(keySymbol),
		.continueKey(continueKey),
		.plot(plot),
		.pixelColour(pixelColour),
		.pixelRegion(pixelRegion),
		.pixelIndex(pixelIndex)
	);

	// every burst of plot becomes one run with its colour, region and length
	always @(posedge clock) begin
		cycle++;
		if (cycle >= timeoutCycles) begin
			$display("run timed out after %0d cycles", cycle);
			$display("Something failed");
			$finish;
		end else if (plot) begin
			if (!inRun) begin
				inRun = 1'b1;
				curColour = pixelColour;
				curRegion = pixelRegion;
				curLength = 0;
				curStart = cycle;
			end
			curLength++;
		end else if (inRun) begin
			inRun = 1'b0;
			runColour.push_back(curColour);
			runRegion.push_back(curRegion);
			runLength.push_back(curLength);
			runStart.push_back(curStart);
			runEnd.push_back(cycle - 1);
		end
	end

	task automatic noteFailure(input string what);
		errorCount++;
		$display("%s", what);
	endtask

	quietUntilStart: assert property (@(posedge clock) disable iff (reset)
		idlePhase |-> !plot) else noteFailure("plot went high before the first start press");
	startLatency: assert property (@(posedge clock) disable iff (reset)
		start && idlePhase |-> ##1 !plot ##1 plot)
		else noteFailure("first pixel did not come two cycles after start");
	firstPixelIndex: assert property (@(posedge clock) disable iff (reset)
		$rose(plot) |-> pixelIndex == 15'd0) else noteFailure("a run did not begin at pixel 0");
	indexCounts: assert property (@(posedge clock) disable iff (reset)
		plot && $past(plot) |-> pixelIndex == $past(pixelIndex) + 15'd1)
		else noteFailure("pixel index skipped inside a run");
	runSteady: assert property (@(posedge clock) disable iff (reset)
		plot && $past(plot) |-> $stable(pixelColour) && $stable(pixelRegion))
		else noteFailure("colour or region changed inside a run");
	badLevelQuiet: assert property (@(posedge clock) disable iff (reset)
		quietWindow |-> !plot) else noteFailure("an illegal level started drawing");
	noEarlyAnswer: assert property (@(posedge clock) disable iff (reset)
		plot && pixelRegion == answer |-> answersAllowed)
		else noteFailure("an answer was painted while the sequence was showing");

	// each wait ends 1 ns after a rising edge, where inputs are driven
	task automatic stepCycles(input int count);
		repeat (count) @(posedge clock);
		#1;
	endtask

	task automatic pulseStart();
		start = 1'b1;
		stepCycles(1);
		start = 1'b0;
	endtask

	task automatic pressKey(input symbolT key);
		keySymbol = key;
		keyPressed = 1'b1;
		stepCycles(1);
		keyPressed = 1'b0;
	endtask

	task automatic nextRun(output int idx);
		while (runColour.size() <= runsTaken)
			stepCycles(1);
		idx = runsTaken;
		runsTaken++;
	endtask

	task automatic checkValue(input string testName, input string what, input int expected,
			input int actual);
		assert (expected == actual) else begin
			errorCount++;
			$display("** Error %s: %s expected %0d actual %0d", testName, what, expected, actual);
		end
	endtask

	task automatic checkRun(input string testName, input int idx, input paletteT colour,
			input regionT region, input int length);
		assert (colour == runColour[idx]) else begin
			errorCount++;
			$display("** Error %s: colour expected %s actual %s", testName, colour.name(),
				runColour[idx].name());
		end
		checkValue(testName, "region", region, runRegion[idx]);
		checkValue(testName, "run length", length, runLength[idx]);
	endtask

	task automatic showSymbols(input string testName, input int lvl);
		int idx;
		int prevIdx;
		answersAllowed = 1'b0;
		for (int i = 0; i < sequenceLength; i++) begin
			nextRun(idx);
			checkValue(testName, "symbol region", canvas, runRegion[idx]);
			checkValue(testName, "symbol length", canvasPixels, runLength[idx]);
			assert (runColour[idx] inside {red, green, blue, yellow}) else begin
				errorCount++;
				$display("** Error %s: colour expected red, green, blue or yellow actual %s",
					testName, runColour[idx].name());
			end
			// the button colours follow the palette in order from red
			shown[i] = symbolT'(runColour[idx] - red);
			if (i > 0) begin
				assert (runStart[idx] - runEnd[prevIdx] >= lvl * pauseUnit) else begin
					errorCount++;
					$display("** Error %s: pause expected at least %0d actual %0d", testName,
						lvl * pauseUnit, runStart[idx] - runEnd[prevIdx]);
				end
			end
			// stray keys while the sequence shows must leave no trace
			if (i == 0 || i == 2)
				pressKey(symbolT'(i));
			prevIdx = idx;
		end
		nextRun(idx);
		checkRun(testName, idx, black, canvas, canvasPixels);
		answersAllowed = 1'b1;
	endtask

	task automatic answerKeys(input string testName, input int badSlot, input paletteT verdict);
		int idx;
		int offset;
		symbolT key;
		for (int i = 0; i < sequenceLength; i++) begin
			key = shown[i];
			if (i == badSlot) begin
				offset = $random(seed);
				key = shown[i] + symbolT'(1 + (offset & 32'h7fffffff) % 3);
			end
			pressKey(key);
			nextRun(idx);
			checkRun(testName, idx, paletteT'(red + key), answer, answerPixels);
		end
		nextRun(idx);
		checkRun(testName, idx, verdict, canvas, canvasPixels);
	endtask

	task automatic finishTest(input string testName);
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("test %s passed", testName);
		end else begin
			failCount++;
			$display("test %s failed with %0d errors", testName, errorCount - errorsBefore);
		end
		errorsBefore = errorCount;
	endtask

	initial begin
		seed = 595;
		start = 1'b0;
		level = '0;
		keyPressed = 1'b0;
		keySymbol = '0;
		continueKey = 1'b0;
		idlePhase = 1'b1;
		quietWindow = 1'b0;
		answersAllowed = 1'b0;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		errorsBefore = 0;
		runsTaken = 0;
		wait (reset === 1'b0);

		stepCycles(20);
		start = 1'b1;
		stepCycles(1);
		start = 1'b0;
		idlePhase = 1'b0;
		nextRun(runIdx);
		checkRun("start screen", runIdx, startScreen, canvas, canvasPixels);
		finishTest("start screen");

		quietWindow = 1'b1;
		level = 3'd0;
		pulseStart();
		stepCycles(4);
		level = 3'd7;
		pulseStart();
		stepCycles(200);
		quietWindow = 1'b0;
		level = 3'd3;
		pulseStart();
		nextRun(runIdx);
		checkRun("level check", runIdx, gameScreen, full, fullPixels);
		finishTest("level check");

		showSymbols("symbol showing", 3);
		finishTest("symbol showing");

		answerKeys("answer and win", -1, winScreen);
		finishTest("answer and win");

		continueKey = 1'b1;
		stepCycles(1);
		continueKey = 1'b0;
		nextRun(runIdx);
		checkRun("continue and lose", runIdx, startScreen, canvas, canvasPixels);
		level = 3'd1;
		pulseStart();
		nextRun(runIdx);
		checkRun("continue and lose", runIdx, gameScreen, full, fullPixels);
		showSymbols("continue and lose", 1);
		wrongSlot = ($random(seed) & 32'h7fffffff) % sequenceLength;
		answerKeys("continue and lose", wrongSlot, loseScreen);
		finishTest("continue and lose");

		$display("tests passed %0d, tests failed %0d", passCount, failCount);
		if (failCount == 0 && errorCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
logic/gamePkg.sv
logic/drawIf.sv
logic/gameControl.sv
logic/screenPainter.sv
logic/sequenceStore.sv
logic/pauseTimer.sv
logic/answerCheck.sv
logic/colourMemoryGame.sv
verification/clockGen.sv
verification/gameTb.sv
